// File: pond_top.f
verilog/pond_data_pkg.sv
verilog/pond_cfg_pkg.sv
verilog/loop_iter.sv
verilog/stride_addr_gen.sv
verilog/sched_gen.sv
verilog/pond_accessor.sv
verilog/pond_mem.sv
verilog/pond_top.sv
tb/pond_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the pond testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
build_log="build.log"
sim_log="sim.log"

verilator --binary --assert -Wno-fatal \
  --top-module pond_tb \
  -f pond_top.f \
  -Mdir "${build_dir}" \
  -o pond_sim > "${build_log}" 2>&1
status=$?
if [ ${status} -ne 0 ]; then
  cat "${build_log}"
  echo "build failed with status ${status}"
  exit 1
fi

"./${build_dir}/pond_sim" > "${sim_log}" 2>&1
status=$?
cat "${sim_log}"
if [ ${status} -ne 0 ]; then
  echo "simulation exited with status ${status}"
  exit 1
fi

if grep -q "^=== PASS ===$" "${sim_log}"; then
  echo "simulation passed"
  exit 0
fi

echo "pass message not found in ${sim_log}"
exit 1

// File: tb/pond_tb.sv
module pond_tb
  import pond_data_pkg::*;
  import pond_cfg_pkg::*;
();

  localparam int lfsr_seed = 87417;
  localparam int max_sched = 64;

  // one expected access of a pass
  typedef struct packed {
    cycle_t    cyc;
    mem_addr_t addr;
  } sched_ent_t;

  logic          clk;
  logic          rst_n;
  logic          clk_en;
  logic          tile_en;
  logic          flush;
  word_t         data_in;
  accessor_cfg_t write_cfg;
  accessor_cfg_t read_cfg;
  word_t         data_out;
  logic          data_out_valid;

  sched_ent_t  wr_list [max_sched];
  sched_ent_t  rd_list [max_sched];
  int          wr_len;
  int          rd_len;
  int          wr_idx;
  int          rd_idx;
  word_t       model_mem [pond_depth];
  cycle_t      model_count;
  logic        wrapped;    // model counter has passed 16'hffff since the last flush
  logic        exp_valid;
  word_t       exp_data;
  logic [15:0] lfsr_state;
  int          dut_reads;
  int          cycle_total = 0;
  int          budget = 0;

  pond_top #(
    .count_width (16)
  ) u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_en         (clk_en),
    .tile_en        (tile_en),
    .flush          (flush),
    .data_in        (data_in),
    .write_cfg      (write_cfg),
    .read_cfg       (read_cfg),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  always @(posedge clk) begin
    cycle_total <= cycle_total + 1;
    if (cycle_total > 2 * budget) begin
      abort_run("timeout: the run went on longer than its schedules allow");
    end
  end

  // valid pulses seen on the read port since reset
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dut_reads <= 0;
    end else if (data_out_valid) begin
      dut_reads <= dut_reads + 1;
    end
  end

  a_valid_matches : assert property (
    @(posedge clk) disable iff (!rst_n)
    data_out_valid == exp_valid
  ) else abort_run($sformatf("[FAIL] data_out_valid got %h expected %h",
                             $sampled(data_out_valid), $sampled(exp_valid)));

  a_data_matches : assert property (
    @(posedge clk) disable iff (!rst_n)
    data_out_valid |-> data_out == exp_data
  ) else abort_run($sformatf("[FAIL] data_out got %h expected %h",
                             $sampled(data_out), $sampled(exp_data)));

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
  endfunction

  task automatic draw_word(output word_t w);
    w = '0;
    for (int b = 0; b < 16; b++) begin
      w = {w[14:0], lfsr_state[15]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic accessor_cfg_t make_cfg(
    input logic [1:0]  dim,
    input logic [15:0] range_inner,
    input logic [15:0] range_outer,
    input mem_addr_t   addr_start,
    input mem_addr_t   addr_si,
    input mem_addr_t   addr_so,
    input cycle_t      cyc_start,
    input cycle_t      cyc_si,
    input cycle_t      cyc_so
  );
    accessor_cfg_t c;
    c.loop.dimensionality = dim;
    c.loop.ranges[0]      = range_inner;
    c.loop.ranges[1]      = range_outer;
    c.addr.start          = addr_start;
    c.addr.stride_inner   = addr_si;
    c.addr.stride_outer   = addr_so;
    c.sched.start         = cyc_start;
    c.sched.stride_inner  = cyc_si;
    c.sched.stride_outer  = cyc_so;
    return c;
  endfunction

  // walks the nested loops and lists every access of one pass in order
  task automatic build_list(input accessor_cfg_t c, input logic is_read);
    int         n_inner;
    int         n_outer;
    int         total;
    int         pos;
    mem_addr_t  addr_off;
    cycle_t     cyc_off;
    sched_ent_t e;
    n_inner  = int'(c.loop.ranges[0]) + 1;
    n_outer  = (c.loop.dimensionality == 2'd2) ? int'(c.loop.ranges[1]) + 1 : 1;
    total    = (c.loop.dimensionality == 2'd0) ? 0 : n_inner * n_outer;
    pos      = 0;
    addr_off = '0;
    cyc_off  = '0;
    for (int k = 0; k < total; k++) begin
      e.cyc  = c.sched.start + cyc_off;
      e.addr = c.addr.start + addr_off;
      if (is_read) begin
        rd_list[k] = e;
      end else begin
        wr_list[k] = e;
      end
      if (pos == n_inner - 1) begin
        pos      = 0; // inner level wraps and the outer strides take over
        addr_off = addr_off + c.addr.stride_outer;
        cyc_off  = cyc_off + c.sched.stride_outer;
      end else begin
        pos      = pos + 1;
        addr_off = addr_off + c.addr.stride_inner;
        cyc_off  = cyc_off + c.sched.stride_inner;
      end
    end
    if (is_read) begin
      rd_len = total;
    end else begin
      wr_len = total;
    end
  endtask

  function automatic int last_cycle();
    int m;
    m = 0;
    if (wr_len > 0) begin
      m = int'(wr_list[wr_len - 1].cyc);
    end
    if (rd_len > 0 && int'(rd_list[rd_len - 1].cyc) > m) begin
      m = int'(rd_list[rd_len - 1].cyc);
    end
    return m;
  endfunction

  function automatic logic fire_due();
    return (wr_idx < wr_len && wr_list[wr_idx].cyc == model_count) ||
           (rd_idx < rd_len && rd_list[rd_idx].cyc == model_count);
  endfunction

  // drives one clock cycle from a falling edge to the next and updates the model
  task automatic run_cycle(input logic ce, input logic te, input logic fl);
    logic en_now;
    logic wr_fire;
    logic rd_fire;
    en_now  = ce && te;
    wr_fire = en_now && (wr_idx < wr_len) && (wr_list[wr_idx].cyc == model_count);
    rd_fire = en_now && (rd_idx < rd_len) && (rd_list[rd_idx].cyc == model_count);
    clk_en  = ce;
    tile_en = te;
    flush   = fl;
    draw_word(data_in);
    exp_valid = rd_fire;
    exp_data  = rd_fire ? model_mem[rd_list[rd_idx].addr] : '0; // old word wins over a write
    @(negedge clk);
    if (wr_fire) begin
      model_mem[wr_list[wr_idx].addr] = data_in;
    end
    if (en_now && fl) begin
      model_count = '0;
      wr_idx      = 0;
      rd_idx      = 0;
      wrapped     = 1'b0;
    end else if (en_now) begin
      if (model_count == 16'hffff) begin
        wrapped = 1'b1;
      end
      model_count = model_count + 1'b1;
      if (wr_fire) begin
        wr_idx = wr_idx + 1;
      end
      if (rd_fire) begin
        rd_idx = rd_idx + 1;
      end
    end
  endtask

  task automatic wait_reads(input int base, input int n);
    while (dut_reads - base < n) begin
      run_cycle(1'b1, 1'b1, 1'b0);
    end
  endtask

  // the config only changes under flush so no address moves in a plain cycle
  task automatic start_test(input accessor_cfg_t wcfg, input accessor_cfg_t rcfg,
                            input int extra);
    run_cycle(1'b1, 1'b1, 1'b1);
    write_cfg = wcfg;
    read_cfg  = rcfg;
    build_list(wcfg, 1'b0);
    build_list(rcfg, 1'b1);
    run_cycle(1'b1, 1'b1, 1'b1);
    budget = budget + last_cycle() + extra;
  endtask

  initial begin
    accessor_cfg_t cfg_a_wr;
    accessor_cfg_t cfg_a_rd;
    accessor_cfg_t cfg_b_wr;
    accessor_cfg_t cfg_b_rd;
    accessor_cfg_t cfg_off_rd;
    int            base;
    int            quiet_end;
    cfg_a_wr   = make_cfg(2'd1, 16'd7, 16'd0, 5'd0, 5'd1, 5'd0, 16'd4, 16'd1, 16'd0);
    cfg_a_rd   = make_cfg(2'd1, 16'd7, 16'd0, 5'd0, 5'd1, 5'd0, 16'd20, 16'd2, 16'd0);
    cfg_b_wr   = make_cfg(2'd2, 16'd3, 16'd2, 5'd2, 5'd1, 5'd5, 16'd3, 16'd1, 16'd3);
    cfg_b_rd   = make_cfg(2'd2, 16'd2, 16'd3, 5'd2, 5'd8, 5'd17, 16'd40, 16'd2, 16'd4);
    cfg_off_rd = make_cfg(2'd0, 16'd7, 16'd0, 5'd0, 5'd1, 5'd0, 16'd20, 16'd2, 16'd0);
    rst_n       = 1'b0;
    clk_en      = 1'b1;
    tile_en     = 1'b1;
    flush       = 1'b0;
    data_in     = '0;
    write_cfg   = cfg_a_wr;
    read_cfg    = cfg_a_rd;
    lfsr_state  = 16'(lfsr_seed);
    model_count = '0;
    wr_idx      = 0;
    rd_idx      = 0;
    wrapped     = 1'b0;
    exp_valid   = 1'b0;
    exp_data    = '0;
    build_list(cfg_a_wr, 1'b0);
    build_list(cfg_a_rd, 1'b1);
    budget = last_cycle() + 65536; // the first test also runs past the counter wrap
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // one-level pass that keeps going until the counter wraps past the schedule
    base = dut_reads;
    wait_reads(base, rd_len);
    while (!(wrapped && model_count > rd_list[rd_len - 1].cyc)) begin
      run_cycle(1'b1, 1'b1, 1'b0);
    end

    start_test(cfg_b_wr, cfg_b_rd, 0);
    base = dut_reads;
    wait_reads(base, rd_len);

    // flush part way through the writes and away from any scheduled access
    start_test(cfg_b_wr, cfg_b_rd, 24);
    base = dut_reads;
    while (wr_idx < 5) begin
      run_cycle(1'b1, 1'b1, 1'b0);
    end
    while (fire_due()) begin
      run_cycle(1'b1, 1'b1, 1'b0);
    end
    run_cycle(1'b1, 1'b1, 1'b1);
    wait_reads(base, rd_len);

    // stalls by clk_en and then by tile_en
    start_test(cfg_a_wr, cfg_a_rd, 9);
    base = dut_reads;
    while (wr_idx < 3) begin
      run_cycle(1'b1, 1'b1, 1'b0);
    end
    repeat (4) run_cycle(1'b0, 1'b1, 1'b0);
    while (dut_reads - base < 2) begin
      run_cycle(1'b1, 1'b1, 1'b0);
    end
    repeat (5) run_cycle(1'b1, 1'b0, 1'b0);
    wait_reads(base, rd_len);

    // the disabled read side is watched over the span its schedule would have covered
    start_test(cfg_a_wr, cfg_off_rd, 40);
    while (wr_idx < wr_len) begin
      run_cycle(1'b1, 1'b1, 1'b0);
    end
    quiet_end = int'(cfg_off_rd.sched.start) +
                (int'(cfg_off_rd.loop.ranges[0]) + 1) * int'(cfg_off_rd.sched.stride_inner);
    while (int'(model_count) <= quiet_end) begin
      run_cycle(1'b1, 1'b1, 1'b0);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: verilog/loop_iter.sv
module loop_iter
  import pond_cfg_pkg::*;
#(
  parameter int count_width = 16
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      en,
  input  logic      flush,
  input  logic      step,
  input  loop_cfg_t cfg,
  output level_e    level,
  output logic      restart
);

  logic [loop_levels-1:0][count_width-1:0] cnt;
  logic [loop_levels-1:0]                  maxed;

  // a level outside the configured dimensionality counts as already maxed
  always_comb begin
    for (int i = 0; i < loop_levels; i++) begin
      maxed[i] = (cfg.dimensionality <= i) ||
                 (cnt[i] == count_width'(cfg.ranges[i]));
    end
  end

  assign level   = maxed[0] ? level_outer : level_inner;
  assign restart = &maxed; // also high for ever when the accessor is disabled

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (en) begin
      if (flush || (step && restart)) begin
        cnt <= '0;
      end else if (step) begin
        if (level == level_inner) begin
          cnt[0] <= cnt[0] + 1'b1;
        end else begin
          cnt[0] <= '0; // inner wraps while outer advances
          cnt[1] <= cnt[1] + 1'b1;
        end
      end
    end
  end

  // counting stops at loop_levels and a larger value would be silently truncated
  a_dim_in_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg.dimensionality <= loop_levels
  );

endmodule

// File: verilog/pond_accessor.sv
module pond_accessor
  import pond_data_pkg::*;
  import pond_cfg_pkg::*;
#(
  parameter int count_width = 16
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          en,
  input  logic          flush,
  input  cycle_t        cycle_count,
  input  accessor_cfg_t cfg,
  output access_t       access
);

  level_e    level;
  logic      restart;
  logic      fire;
  mem_addr_t addr;

  loop_iter #(
    .count_width (count_width)
  ) u_loop_iter (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (en),
    .flush   (flush),
    .step    (fire),
    .cfg     (cfg.loop),
    .level   (level),
    .restart (restart)
  );

  stride_addr_gen #(
    .addr_width ($bits(mem_addr_t))
  ) u_addr_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .flush        (flush),
    .step         (fire),
    .restart      (restart),
    .level        (level),
    .start_addr   (cfg.addr.start),
    .stride_inner (cfg.addr.stride_inner),
    .stride_outer (cfg.addr.stride_outer),
    .addr         (addr)
  );

  sched_gen u_sched_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .flush        (flush),
    .restart      (restart),
    .level        (level),
    .cycle_count  (cycle_count),
    .start_cycle  (cfg.sched.start),
    .stride_inner (cfg.sched.stride_inner),
    .stride_outer (cfg.sched.stride_outer),
    .fire         (fire)
  );

  // a disabled accessor still fires once to close its gate but never reaches the memory
  assign access.valid = fire && (cfg.loop.dimensionality != '0);
  assign access.addr  = addr;

  // the address only moves on an access or a flush, and never while stalled
  a_addr_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (!en || (!access.valid && !flush)) |=> $stable(access.addr)
  );

endmodule

// File: verilog/pond_cfg_pkg.sv
package pond_cfg_pkg;

  localparam int loop_levels = 2;

  // loop level that is being stepped by the iterator
  typedef enum logic {
    level_inner,
    level_outer
  } level_e;

  typedef struct packed {
    logic [1:0]                   dimensionality; // 0 disables the accessor
    logic [loop_levels-1:0][15:0] ranges;         // each level runs range+1 times
  } loop_cfg_t;

  typedef struct packed {
    pond_data_pkg::mem_addr_t start;
    pond_data_pkg::mem_addr_t stride_inner;
    pond_data_pkg::mem_addr_t stride_outer; // jump applied when the inner level wraps
  } addr_cfg_t;

  typedef struct packed {
    pond_data_pkg::cycle_t start;
    pond_data_pkg::cycle_t stride_inner;
    pond_data_pkg::cycle_t stride_outer;
  } sched_cfg_t;

  // everything one accessor needs, held stable for a whole run
  typedef struct packed {
    loop_cfg_t  loop;
    addr_cfg_t  addr;
    sched_cfg_t sched;
  } accessor_cfg_t;

endpackage

// File: verilog/pond_data_pkg.sv
package pond_data_pkg;

  // fixed geometry of the pond storage
  localparam int pond_depth = 32;

  typedef logic [15:0] word_t;

  // wide enough to index every pond word
  typedef logic [$clog2(pond_depth)-1:0] mem_addr_t;

  // shared cycle counter, also the unit of every scheduled cycle
  typedef logic [15:0] cycle_t;

  // one scheduled access as seen by the memory
  typedef struct packed {
    logic      valid;
    mem_addr_t addr;
  } access_t;

endpackage

// File: verilog/pond_mem.sv
module pond_mem
  import pond_data_pkg::*;
(
  input  logic      clk,
  input  logic      en,
  input  access_t   wr,
  input  word_t     wr_data,
  input  mem_addr_t rd_addr,
  output word_t     rd_data
);

  word_t mem [pond_depth];

  always_ff @(posedge clk) begin
    if (en && wr.valid) begin
      mem[wr.addr] <= wr_data;
    end
  end

  // same cycle read sees the word before any write at this edge
  assign rd_data = mem[rd_addr];

endmodule

// File: verilog/pond_top.sv
module pond_top
  import pond_data_pkg::*;
  import pond_cfg_pkg::*;
#(
  parameter int count_width = 16
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          clk_en,
  input  logic          tile_en,
  input  logic          flush,
  input  word_t         data_in,
  input  accessor_cfg_t write_cfg,
  input  accessor_cfg_t read_cfg,
  output word_t         data_out,
  output logic          data_out_valid
);

  logic    en;
  cycle_t  cycle_count;
  access_t write_access;
  access_t read_access;

  // tile enable is a plain enable here, no gated clock
  assign en = clk_en && tile_en;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_count <= '0;
    end else if (en) begin
      if (flush) begin
        cycle_count <= '0;
      end else begin
        cycle_count <= cycle_count + 1'b1; // wraps so schedules are compared modulo 2^16
      end
    end
  end

  pond_accessor #(
    .count_width (count_width)
  ) u_write_acc (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .cfg         (write_cfg),
    .access      (write_access)
  );

  pond_accessor #(
    .count_width (count_width)
  ) u_read_acc (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .cfg         (read_cfg),
    .access      (read_access)
  );

  pond_mem u_mem (
    .clk     (clk),
    .en      (en),
    .wr      (write_access),
    .wr_data (data_in),
    .rd_addr (read_access.addr),
    .rd_data (data_out)
  );

  assign data_out_valid = read_access.valid;

endmodule

// File: verilog/sched_gen.sv
module sched_gen
  import pond_data_pkg::*;
  import pond_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   en,
  input  logic   flush,
  input  logic   restart,
  input  level_e level,
  input  cycle_t cycle_count,
  input  cycle_t start_cycle,
  input  cycle_t stride_inner,
  input  cycle_t stride_outer,
  output logic   fire
);

  cycle_t sched_cycle;
  logic   done;

  // the schedule is just another strided sequence, stepped by our own fire
  stride_addr_gen #(
    .addr_width($bits(cycle_t))
  ) u_sched_addr (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .flush        (flush),
    .step         (fire),
    .restart      (restart),
    .level        (level),
    .start_addr   (start_cycle),
    .stride_inner (stride_inner),
    .stride_outer (stride_outer),
    .addr         (sched_cycle)
  );

  assign fire = en && !done && (cycle_count == sched_cycle);

  // once the last access has gone out only a flush reopens the gate
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (en) begin
      if (flush) begin
        done <= 1'b0;
      end else if (fire && restart) begin
        done <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/stride_addr_gen.sv
module stride_addr_gen
  import pond_cfg_pkg::*;
#(
  parameter int addr_width = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  logic                  flush,
  input  logic                  step,
  input  logic                  restart,
  input  level_e                level,
  input  logic [addr_width-1:0] start_addr,
  input  logic [addr_width-1:0] stride_inner,
  input  logic [addr_width-1:0] stride_outer,
  output logic [addr_width-1:0] addr
);

  logic [addr_width-1:0] offset;
  logic [addr_width-1:0] stride;

  assign stride = (level == level_outer) ? stride_outer : stride_inner;
  assign addr   = start_addr + offset; // wraps at addr_width

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset <= '0;
    end else if (en) begin
      if (flush || (step && restart)) begin
        offset <= '0;
      end else if (step) begin
        offset <= offset + stride;
      end
    end
  end

endmodule
